//--- tb.f
src/predecodePkg.sv
src/predecodeCtrl.sv
src/parcelCounter.sv
src/bundleWindow.sv
src/instrClassifier.sv
src/predecodeTop.sv
testbench/tbPredecode.sv

//--- Makefile
SOURCES := $(wildcard src/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/VtbPredecode
	out="$$(./obj_dir/VtbPredecode)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

obj_dir/VtbPredecode: tb.f $(SOURCES)
	verilator --binary --timing -f tb.f --top-module tbPredecode -Mdir obj_dir

clean:
	rm -rf obj_dir

//--- testbench/tbPredecode.sv
`timescale 1ns/1ns

module tbPredecode import predecodePkg::*; ();

  localparam int NumBundles = 300;
  localparam int CycleLimit = NumBundles * 120 + 20;
  localparam int CheckWidth = WindowWidth + OffWidth + LenWidth + ClassWidth;

  logic clk;
  logic rstN;
  logic bundleReq;
  logic [BundleWidth-1:0] bundle;
  logic [OffWidth-1:0] startOff;
  logic bundleAck;
  logic [CntWidth-1:0] insCount;
  logic [CntWidth-1:0] jumpCount;
  logic hasJumps;
  logic overflowError;
  logic jumpError;
  logic insReq;
  logic [WindowWidth-1:0] insWord;
  logic [OffWidth-1:0] insOff;
  logic [LenWidth-1:0] insLen;
  logic [ClassWidth-1:0] insClass;
  logic insAck;

  logic [WindowWidth-1:0] expWord[$];
  int expOff[$];
  int expLen[$];
  logic [ClassWidth-1:0] expClass[$];
  int expCount;
  int expJumps;
  logic expOverflow;
  int cycles;
  logic prevReq;
  logic prevAck;
  logic [CheckWidth-1:0] prevData;

  predecodeTop dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic mismatch(input string sig, input logic [CheckWidth-1:0] got,
                          input logic [CheckWidth-1:0] exp);
    $display("ERR %0t %s got %0h expected %0h", $time, sig, got, exp);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkValue(input string sig, input logic [CheckWidth-1:0] got,
                            input logic [CheckWidth-1:0] exp);
    assert (got === exp) else mismatch(sig, got, exp);
  endtask

  // Class vector straight from the opcode tables.
  function automatic logic [ClassWidth-1:0] classOf(input logic [31:0] w, input logic isLong);
    logic [ClassWidth-1:0] c;
    int op;
    int sf;
    int os;
    c = '0;
    op = w[7:0];
    sf = w[15:13];
    os = w[5:0];
    if (isLong) begin
      if (op < 40) c[w[2] ? ClsMul : ClsAlu] = 1'b1;
      else if (op <= 45) c[ClsShift] = 1'b1;
      else if (op <= 53) c[ClsAlu] = 1'b1;
      else if ((op >= 64 && op <= 95) || (op >= 112 && op <= 127)) begin
        c[op % 2 ? ClsStore : ClsLoad] = 1'b1;
      end else if (op >= 160 && op <= 175) begin
        c[ClsJump] = 1'b1;
        c[ClsAlu] = 1'b1;
      end else if (op == OpLongCondJump || op == OpUncondJump) c[ClsJump] = 1'b1;
      else if (op == OpIndirGroup) begin
        if (sf <= 3) c[ClsJump] = 1'b1;  // Sub-functions 4 to 7 carry no class.
        if (sf == 0 || sf == 3) c[ClsIndir] = 1'b1;
        if (sf == 1 || sf == 2) c[ClsStore] = 1'b1;
      end else if (op == OpSys) c[ClsSys] = 1'b1;
    end else begin
      if (os < 20) c[ClsAlu] = 1'b1;
      else if (os <= 31 && os % 2 == 1) c[ClsShift] = 1'b1;
      else if (os >= 48 && os <= 51) c[ClsJump] = 1'b1;
    end
    return c;
  endfunction

  function automatic logic [7:0] pickOp(input logic jumpy);
    int r;
    r = jumpy ? 5 + $urandom % 4 : $urandom % 11;
    case (r)
      0: return 8'($urandom % 40);
      1: return 8'(40 + $urandom % 14);
      2: return 8'(64 + $urandom % 32);
      3: return 8'(112 + $urandom % 16);
      4: return OpSys;
      5: return 8'(160 + $urandom % 16);
      6: return OpLongCondJump;
      7: return OpUncondJump;
      8: return OpIndirGroup;
      default: return 8'($urandom);
    endcase
  endfunction

  task automatic buildBundle();
    int mode;
    int p;
    int len;
    mode = $urandom % 8;
    bundle <= '0;
    for (int i = 0; i < NumParcels; i++) bundle[i*ParcelWidth +: ParcelWidth] <= 16'($urandom);
    p = 0;
    while (p < NumParcels) begin
      len = (mode == 0) ? 1 : (($urandom % 20 == 0) ? 6 : 1 + $urandom % 5);
      bundle[p*ParcelWidth +: 8] <= pickOp(mode == 1);
      if (p + len - 1 < NumParcels) bundle[StopBase + p + len - 1] <= 1'b1;
      p += len;
    end
    startOff <= ($urandom % 8 == 0) ? 4'd15 : OffWidth'($urandom % NumParcels);
  endtask

  task automatic runModel();
    int idx;
    int p;
    logic [WindowWidth-1:0] w;
    logic [ClassWidth-1:0] c;
    idx = startOff;
    expCount = 0;
    expJumps = 0;
    forever begin
      if (idx >= NumParcels) begin
        expOverflow = (expCount == 0);
        break;
      end
      if (expCount == MaxInstr) begin
        expOverflow = 1'b1;
        break;
      end
      p = idx;
      while (p < NumParcels - 1 && !bundle[StopBase + p]) p++;
      if (p - idx + 1 > MaxLen) begin
        expOverflow = 1'b1;
        break;
      end
      w = '0;
      for (int i = 0; i < MaxLen; i++) begin
        if (idx + i < NumParcels) begin
          w[i*ParcelWidth +: ParcelWidth] = bundle[(idx+i)*ParcelWidth +: ParcelWidth];
        end
      end
      c = classOf(w[31:0], !bundle[StopBase + idx]);
      expWord.push_back(w);
      expOff.push_back(idx);
      expLen.push_back(p - idx + 1);
      expClass.push_back(c);
      expCount++;
      expJumps += c[ClsJump];
      idx = p + 1;
    end
  endtask

  // Handshake rules watched on every edge.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CycleLimit) begin
      $display("Timeout: the DUT stopped answering the handshakes");
      $display("Test failed");
      $fatal(1, "timeout");
    end
    if (insReq && !prevReq) checkValue("insAck at insReq rise", insAck, 1'b0);
    if (insReq && prevReq) checkValue("insReq data", {insWord, insOff, insLen, insClass}, prevData);
    if (prevAck && !bundleAck) checkValue("bundleReq at bundleAck fall", bundleReq, 1'b0);
    prevReq <= insReq;
    prevAck <= bundleAck;
    prevData <= {insWord, insOff, insLen, insClass};
  end

  initial begin
    int waited;
    void'($urandom(63668));
    cycles = 0;
    prevReq = 1'b0;
    prevAck = 1'b0;
    prevData = '0;
    rstN = 1'b0;
    bundleReq = 1'b0;
    bundle = '0;
    startOff = '0;
    insAck = 1'b0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    checkValue("insReq", insReq, 1'b0);
    checkValue("bundleAck", bundleAck, 1'b0);
    for (int b = 0; b < NumBundles; b++) begin
      @(posedge clk);
      buildBundle();
      bundleReq <= 1'b1;
      @(posedge clk);
      runModel();
      waited = 1;
      while (!insReq && !bundleAck) begin
        @(posedge clk);
        waited++;
      end
      checkValue("first response cycles", waited, 4);
      while (!bundleAck) begin
        if (insReq) begin
          checkValue("insOff", insOff, expOff.pop_front());
          checkValue("insLen", insLen, expLen.pop_front());
          checkValue("insWord", insWord, expWord.pop_front());
          checkValue("insClass", insClass, expClass.pop_front());
          repeat ($urandom % 6) @(posedge clk);
          insAck <= 1'b1;
          do @(posedge clk); while (insReq);
          insAck <= 1'b0;
        end
        @(posedge clk);
      end
      checkValue("instructions left in model", expOff.size(), 0);
      checkValue("insCount", insCount, expCount);
      checkValue("jumpCount", jumpCount, expJumps);
      checkValue("hasJumps", hasJumps, expJumps != 0);
      checkValue("overflowError", overflowError, expOverflow);
      checkValue("jumpError", jumpError, expJumps > MaxJumps);
      bundleReq <= 1'b0;
      do @(posedge clk); while (bundleAck);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- src/predecodeTop.sv
`timescale 1ns/1ns

module predecodeTop import predecodePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic bundleReq,
  input  logic [BundleWidth-1:0] bundle,
  input  logic [OffWidth-1:0] startOff,
  output logic bundleAck,
  output logic [CntWidth-1:0] insCount,
  output logic [CntWidth-1:0] jumpCount,
  output logic hasJumps,
  output logic overflowError,
  output logic jumpError,
  output logic insReq,
  output logic [WindowWidth-1:0] insWord,
  output logic [OffWidth-1:0] insOff,
  output logic [LenWidth-1:0] insLen,
  output logic [ClassWidth-1:0] insClass,
  input  logic insAck
);

  logic load;
  logic step;
  logic clear;
  logic scanDone;
  logic overLength;
  logic isJump;
  logic [MagicWidth-1:0] magic;

  predecodeCtrl ctrl (
    .clk(clk),
    .rstN(rstN),
    .bundleReq(bundleReq),
    .insAck(insAck),
    .scanDone(scanDone),
    .bundleAck(bundleAck),
    .insReq(insReq),
    .load(load),
    .step(step),
    .clear(clear)
  );

  parcelCounter counter (
    .clk(clk),
    .rstN(rstN),
    .load(load),
    .step(step),
    .clear(clear),
    .startOff(startOff),
    .insLen(insLen),
    .isJump(isJump),
    .overLength(overLength),
    .index(insOff),            // The issued offset is the scan index.
    .insCount(insCount),
    .jumpCount(jumpCount),
    .hasJumps(hasJumps),
    .overflowError(overflowError),
    .jumpError(jumpError),
    .scanDone(scanDone)
  );

  bundleWindow windowSel (
    .clk(clk),
    .rstN(rstN),
    .load(load),
    .bundle(bundle),
    .index(insOff),
    .window(insWord),
    .magic(magic),
    .insLen(insLen),
    .overLength(overLength)
  );

  instrClassifier classifier (
    .window(insWord),
    .magic(magic),
    .insClass(insClass),
    .isJump(isJump)
  );

endmodule

//--- src/instrClassifier.sv
`timescale 1ns/1ns

module instrClassifier import predecodePkg::*; (
  input  logic [WindowWidth-1:0] window,
  input  logic [MagicWidth-1:0] magic,
  output logic [ClassWidth-1:0] insClass,
  output logic isJump
);

  instrWord_u word;
  logic isLong;
  logic [7:0] opMain;
  logic [2:0] subFunc;
  logic [5:0] opSub;

  logic isBasicAlu;
  logic isBasicMul;
  logic isBasicShift;
  logic isCmpTest;
  logic isLoadStore;
  logic isCondJump;
  logic isDirJump;
  logic isIndirGroup;
  logic isIndirJump;
  logic isCall;
  logic isRet;
  logic isSys;

  logic subIsAlu;
  logic subIsShift;
  logic subIsJump;

  assign word = window[31:0];
  assign isLong = magic[0];  // Next parcel continues the instruction.
  assign opMain = word.longForm.opMain;
  assign subFunc = word.longForm.subFunc;
  assign opSub = word.compact.opSub;

  // Long form.
  assign isBasicAlu = (opMain < 8'd40) && ~opMain[2] && isLong;
  assign isBasicMul = (opMain < 8'd40) && opMain[2] && isLong;
  assign isBasicShift = (opMain >= 8'd40) && (opMain <= 8'd45) && isLong;
  assign isCmpTest = (opMain >= 8'd46) && (opMain <= 8'd53) && isLong;

  // 64 to 95 and 112 to 127.
  assign isLoadStore = (opMain[7:5] == 3'b010 || opMain[7:4] == 4'b0111) && isLong;

  assign isCondJump = (opMain[7:4] == 4'b1010) && isLong;  // 160 to 175.
  assign isDirJump = (opMain == OpLongCondJump || opMain == OpUncondJump) && isLong;

  assign isIndirGroup = (opMain == OpIndirGroup) && isLong;
  assign isIndirJump = isIndirGroup && (subFunc == 3'd0);
  assign isCall = isIndirGroup && (subFunc == 3'd1 || subFunc == 3'd2);
  assign isRet = isIndirGroup && (subFunc == 3'd3);

  assign isSys = (opMain == OpSys) && isLong;

  // Compact 16-bit form.
  assign subIsAlu = (opSub < 6'd20) && ~isLong;
  assign subIsShift = (opSub >= 6'd20) && (opSub <= 6'd31) && opSub[0] && ~isLong;
  assign subIsJump = (opSub[5:2] == 4'b1100) && ~isLong;

  assign insClass[ClsJump] = |{
    isCondJump,
    isDirJump,
    isIndirJump,
    isCall,
    isRet,
    subIsJump
  };

  assign insClass[ClsIndir] = isIndirJump | isRet;

  assign insClass[ClsAlu] = |{
    isBasicAlu,
    isCmpTest,
    isCondJump,  // Compare-and-branch uses the ALU too.
    subIsAlu
  };

  assign insClass[ClsShift] = isBasicShift | subIsShift;
  assign insClass[ClsMul] = isBasicMul;
  assign insClass[ClsLoad] = isLoadStore & ~opMain[0];
  assign insClass[ClsStore] = (isLoadStore & opMain[0]) | isCall;  // Call pushes the link.
  assign insClass[ClsSys] = isSys;

  assign isJump = insClass[ClsJump];

endmodule

//--- src/bundleWindow.sv
`timescale 1ns/1ns

module bundleWindow import predecodePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic load,
  input  logic [BundleWidth-1:0] bundle,
  input  logic [OffWidth-1:0] index,
  output logic [WindowWidth-1:0] window,
  output logic [MagicWidth-1:0] magic,
  output logic [LenWidth-1:0] insLen,
  output logic overLength
);

  logic [ParcelBits-1:0] parcels;
  logic [NumParcels-1:0] stops;
  logic [ParcelBits+WindowWidth-1:0] padParcels;
  logic [NumParcels+MaxLen-1:0] magicStops;
  logic [NumParcels+MaxLen-1:0] endStops;
  logic [MaxLen-1:0] endWin;

  always_ff @(posedge clk) begin
    if (load) begin
      parcels <= bundle[ParcelBits-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stops <= '1;
    end else if (load) begin
      stops <= bundle[StopBase +: NumParcels];
    end
  end

  assign padParcels = {{WindowWidth{1'b0}}, parcels};  // Zero past parcel 14.
  assign window = padParcels[index*ParcelWidth +: WindowWidth];

  assign magicStops = {{MaxLen{1'b1}}, stops};
  assign magic = ~magicStops[index +: MagicWidth];

  // Parcel 14 ends the last instruction whatever its stop bit says.
  assign endStops = {{MaxLen{1'b1}}, 1'b1, stops[NumParcels-2:0]};
  assign endWin = endStops[index +: MaxLen];

  always_comb begin
    insLen = '0;
    overLength = ~|endWin;
    for (int i = MaxLen - 1; i >= 0; i--) begin
      if (endWin[i]) begin
        insLen = LenWidth'(i + 1);  // First stop wins.
      end
    end
  end

endmodule

//--- src/parcelCounter.sv
`timescale 1ns/1ns

module parcelCounter import predecodePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic load,
  input  logic step,
  input  logic clear,
  input  logic [OffWidth-1:0] startOff,
  input  logic [LenWidth-1:0] insLen,
  input  logic isJump,
  input  logic overLength,
  output logic [OffWidth-1:0] index,
  output logic [CntWidth-1:0] insCount,
  output logic [CntWidth-1:0] jumpCount,
  output logic hasJumps,
  output logic overflowError,
  output logic jumpError,
  output logic scanDone
);

  logic pastEnd;
  logic limitHit;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      index <= '0;
      insCount <= '0;
      jumpCount <= '0;
    end else if (clear) begin
      insCount <= '0;
      jumpCount <= '0;
    end else if (load) begin
      index <= startOff;
    end else if (step) begin
      // Parcel 14 always ends an instruction, so the sum stops at 15.
      index <= index + OffWidth'(insLen);
      insCount <= insCount + CntWidth'(1);
      jumpCount <= jumpCount + CntWidth'(isJump);
    end
  end

  assign pastEnd = index >= OffWidth'(NumParcels);
  assign limitHit = insCount == CntWidth'(MaxInstr);
  assign scanDone = pastEnd || limitHit || overLength;

  // Running off the end is normal unless nothing could be issued.
  assign overflowError = pastEnd ? (insCount == '0) : (limitHit || overLength);

  assign hasJumps = |jumpCount;
  assign jumpError = jumpCount > CntWidth'(MaxJumps);

endmodule

//--- src/predecodeCtrl.sv
`timescale 1ns/1ns

module predecodeCtrl import predecodePkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic bundleReq,
  input  logic insAck,
  input  logic scanDone,
  output logic bundleAck,
  output logic insReq,
  output logic load,
  output logic step,
  output logic clear
);

  logic [StateWidth-1:0] state;
  logic [StateWidth-1:0] nextState;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= StIdle;
      step <= 1'b0;
    end else begin
      state <= nextState;
      step <= (state == StIssue) && insAck;  // One pulse per accepted instruction.
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      StIdle: begin
        if (bundleReq) begin
          nextState = StLoad;
        end
      end
      // Index and bundle settle for one cycle before the first decision.
      StLoad: nextState = StWaitAckLow;
      StIssue: begin
        if (insAck) begin
          nextState = StWaitAckLow;
        end
      end
      StWaitAckLow: begin
        if (!insAck) begin
          nextState = scanDone ? StFinish : StIssue;
        end
      end
      StFinish: nextState = StWaitReqLow;
      StWaitReqLow: begin
        if (!bundleReq) begin
          nextState = StIdle;
        end
      end
      default: nextState = StIdle;
    endcase
  end

  assign load = (state == StLoad);
  assign clear = (state == StIdle);  // Counts start from zero for every bundle.
  assign insReq = (state == StIssue);
  assign bundleAck = (state == StFinish) || (state == StWaitReqLow);

endmodule

//--- src/predecodePkg.sv
package predecodePkg;

  // Bundle geometry.
  localparam int ParcelWidth = 16;
  localparam int NumParcels = 15;
  localparam int ParcelBits = NumParcels * ParcelWidth;
  localparam int BundleWidth = 256;
  localparam int StopBase = 240;   // Stop bit of parcel 0.
  localparam int WindowWidth = 80;

  // Limits per instruction and per bundle.
  localparam int MaxLen = 5;       // In parcels.
  localparam int MaxInstr = 12;
  localparam int MaxJumps = 4;

  localparam int OffWidth = 4;
  localparam int LenWidth = 3;
  localparam int CntWidth = 4;
  localparam int MagicWidth = 4;

  // Class vector bit positions.
  localparam int ClassWidth = 8;
  localparam int ClsJump = 0;
  localparam int ClsIndir = 1;
  localparam int ClsAlu = 2;
  localparam int ClsShift = 3;
  localparam int ClsMul = 4;
  localparam int ClsLoad = 5;
  localparam int ClsStore = 6;
  localparam int ClsSys = 7;

  localparam logic [7:0] OpLongCondJump = 8'd180;
  localparam logic [7:0] OpUncondJump = 8'd181;
  localparam logic [7:0] OpIndirGroup = 8'd182;  // Indirect jump, call, return.
  localparam logic [7:0] OpSys = 8'd255;

  // Scan FSM encoding.
  localparam int StateWidth = 3;
  localparam logic [StateWidth-1:0] StIdle = 3'd0;
  localparam logic [StateWidth-1:0] StLoad = 3'd1;
  localparam logic [StateWidth-1:0] StIssue = 3'd2;
  localparam logic [StateWidth-1:0] StWaitAckLow = 3'd3;
  localparam logic [StateWidth-1:0] StFinish = 3'd4;
  localparam logic [StateWidth-1:0] StWaitReqLow = 3'd5;

  // Low instruction word as seen by the two encodings.
  typedef union packed {
    struct packed {
      logic [15:0] operands;
      logic [2:0] subFunc;
      logic [4:0] regField;
      logic [7:0] opMain;
    } longForm;
    struct packed {
      logic [25:0] operands;
      logic [5:0] opSub;
    } compact;
  } instrWord_u;

endpackage
